// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := cpu_tb
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/alu.sv ====
// 32-bit alu
module alu (
  input  logic              [31:0] a,
  input  logic              [31:0] b,
  input  mips_pkg::alu_op_e        op,
  output logic              [31:0] result,
  output logic                     zero
);
  import mips_pkg::*;

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};  // signed compare
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);  // beq decision

  // op comes from the decoder, which must only ever produce listed codes
  always_comb begin
    a_op_defined: assert (op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT})
      else $error("alu: undefined op %0d", op);
  end

endmodule

// ==== hw/cpu_top.sv ====
// single-cycle mips core
module cpu_top #(
  parameter int          IMEM_WORDS = 256,
  parameter logic [31:0] RESET_PC   = 32'h0
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              load_en,
  input  logic [31:0]       load_addr,
  input  logic [31:0]       load_data,
  input  mips_pkg::wb_s2m_t wb_in,
  output mips_pkg::wb_m2s_t wb_out
);
  import mips_pkg::*;

  logic [31:0] pc;
  logic [31:0] pc_plus4;
  logic [31:0] pc_next;
  logic [31:0] branch_target;
  logic [31:0] jump_addr;
  instr_t      instr;
  ctrl_t       ctrl;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [4:0]  write_addr;
  logic [31:0] imm_ext;
  logic [25:0] jump_target;
  logic [31:0] data_s;
  logic [31:0] data_t;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic        alu_zero;
  logic [31:0] write_data;
  logic [31:0] mem_rdata;
  logic        stall;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (!stall) begin  // hold while the bus cycle is open
      pc <= pc_next;
    end
  end

  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
  assign jump_addr     = {pc_plus4[31:28], jump_target, 2'b00};

  always_comb begin
    if (ctrl.jump) pc_next = jump_addr;
    else if (ctrl.branch && alu_zero) pc_next = branch_target;
    else pc_next = pc_plus4;
  end

  instr_mem #(.IMEM_WORDS(IMEM_WORDS)) imem (
    .clock(clock), .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
    .fetch_addr(pc[31:2]), .instr(instr)
  );

  decode_control dec (
    .instr(instr), .ctrl(ctrl), .rs(rs), .rt(rt), .rd(rd),
    .imm_ext(imm_ext), .jump_target(jump_target)
  );

  always_comb begin
    case (ctrl.dst_sel)
      DST_RD:  write_addr = rd;
      DST_RA:  write_addr = 5'd31;  // jal link register
      default: write_addr = rt;
    endcase
  end

  always_comb begin
    case (ctrl.wb_sel)
      WB_MEM:  write_data = mem_rdata;
      WB_LINK: write_data = pc_plus4;
      default: write_data = alu_result;
    endcase
  end

  reg_file rf (
    .clock(clock), .reset(reset), .read_addr_s(rs), .read_addr_t(rt),
    .write_addr(write_addr), .write_data(write_data),
    .write_en(ctrl.reg_write && !stall), .data_s(data_s), .data_t(data_t)
  );

  assign alu_b = ctrl.alu_src_imm ? imm_ext : data_t;

  alu ex (.a(data_s), .b(alu_b), .op(ctrl.alu_op), .result(alu_result), .zero(alu_zero));

  data_bus_master dbm (
    .clock(clock), .reset(reset), .mem_read(ctrl.mem_read), .mem_write(ctrl.mem_write),
    .addr(alu_result), .wdata(data_t), .wb_in(wb_in), .wb_out(wb_out),
    .rdata(mem_rdata), .stall(stall)
  );

endmodule

// ==== hw/data_bus_master.sv ====
// wishbone data master
module data_bus_master (
  input  logic              clock,
  input  logic              reset,
  input  logic              mem_read,
  input  logic              mem_write,
  input  logic [31:0]       addr,
  input  logic [31:0]       wdata,
  input  mips_pkg::wb_s2m_t wb_in,
  output mips_pkg::wb_m2s_t wb_out,
  output logic [31:0]       rdata,
  output logic              stall
);
  import mips_pkg::*;

  logic        busy;  // bus cycle open
  logic        we_q;
  logic [31:0] adr_q;
  logic [31:0] dat_q;
  logic        req;

  assign req = mem_read | mem_write;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
      we_q <= 1'b0;
    end else if (busy) begin
      if (wb_in.ack) begin  // close on the edge after ack
        busy <= 1'b0;
        we_q <= 1'b0;
      end
    end else if (req) begin
      busy <= 1'b1;
      we_q <= mem_write;
    end
  end

  // payload latched once per cycle and held until ack
  always_ff @(posedge clock) begin
    if (!busy && req) begin
      adr_q <= addr;
      dat_q <= wdata;
    end
  end

  always_comb begin
    wb_out.cyc = busy;
    wb_out.stb = busy;
    wb_out.we  = we_q;
    wb_out.adr = adr_q;
    wb_out.dat = dat_q;
    wb_out.sel = 4'hF;  // word access only
  end

  assign stall = req && !(busy && wb_in.ack);  // retire on the ack edge
  assign rdata = wb_in.dat;                    // written back on that same edge

  a_stb_with_cyc: assert property (
    @(posedge clock) disable iff (reset) wb_out.stb |-> wb_out.cyc
  ) else $error("wb: stb without cyc");

  a_hold_until_ack: assert property (
    @(posedge clock) disable iff (reset)
    (wb_out.stb && !wb_in.ack) |=>
      ($stable(wb_out.adr) && $stable(wb_out.we) && $stable(wb_out.dat))
  ) else $error("wb: request changed before ack");

  a_one_access: assert property (
    @(posedge clock) disable iff (reset) !(mem_read && mem_write)
  ) else $error("wb: read and write requested together");

endmodule

// ==== hw/decode_control.sv ====
// instruction decode and control
module decode_control (
  input  mips_pkg::instr_t instr,
  output mips_pkg::ctrl_t  ctrl,
  output logic [4:0]       rs,
  output logic [4:0]       rt,
  output logic [4:0]       rd,
  output logic [31:0]      imm_ext,
  output logic [25:0]      jump_target
);
  import mips_pkg::*;

  // rs and rt sit at the same bits in r and i format
  assign rs          = instr.i.rs;
  assign rt          = instr.i.rt;
  assign rd          = instr.r.rd;
  assign imm_ext     = {{16{instr.i.imm16[15]}}, instr.i.imm16};
  assign jump_target = instr.j.target26;

  always_comb begin
    ctrl = '0;  // add, rt, alu write-back, nothing enabled
    case (instr.r.opcode)
      OP_RTYPE: begin
        ctrl.reg_write = 1'b1;
        ctrl.dst_sel   = DST_RD;
        case (instr.r.funct)
          FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          default: begin
            ctrl.reg_write = 1'b0;  // unknown funct runs as a nop
            ctrl.illegal   = 1'b1;
          end
        endcase
      end
      OP_ADDIU: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
      end
      OP_LW: begin
        ctrl.alu_src_imm = 1'b1;  // base + offset
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.wb_sel      = WB_MEM;
      end
      OP_SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      OP_BEQ: begin
        ctrl.alu_op = ALU_SUB;  // zero flag gives rs == rt
        ctrl.branch = 1'b1;
      end
      OP_J:   ctrl.jump = 1'b1;
      OP_JAL: begin
        ctrl.jump      = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.dst_sel   = DST_RA;
        ctrl.wb_sel    = WB_LINK;
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

// ==== hw/instr_mem.sv ====
// instruction memory
module instr_mem #(
  parameter int IMEM_WORDS = 256
) (
  input  logic             clock,
  input  logic             load_en,
  input  logic [31:0]      load_addr,   // word index
  input  logic [31:0]      load_data,
  input  logic [29:0]      fetch_addr,  // pc[31:2]
  output mips_pkg::instr_t instr
);
  import mips_pkg::*;

  localparam int AW = $clog2(IMEM_WORDS);

  logic [31:0] mem [IMEM_WORDS];

  // loader port, used while the core sits in reset
  always_ff @(posedge clock) begin
    if (load_en) begin
      mem[load_addr[AW-1:0]] <= load_data;
    end
  end

  assign instr = mem[fetch_addr[AW-1:0]];  // async fetch

  // the loader must stay inside the array, the index is truncated otherwise
  a_load_in_range: assert property (
    @(posedge clock) load_en |-> load_addr < 32'(IMEM_WORDS)
  ) else $error("instr_mem: load_addr %0d out of range", load_addr);

endmodule

// ==== hw/mips_pkg.sv ====
// mips core shared types
package mips_pkg;

  // primary opcodes
  parameter logic [5:0] OP_RTYPE = 6'h00;
  parameter logic [5:0] OP_J     = 6'h02;
  parameter logic [5:0] OP_JAL   = 6'h03;
  parameter logic [5:0] OP_BEQ   = 6'h04;
  parameter logic [5:0] OP_ADDIU = 6'h09;
  parameter logic [5:0] OP_LW    = 6'h23;
  parameter logic [5:0] OP_SW    = 6'h2b;

  // funct codes, r-type only
  parameter logic [5:0] FN_ADDU = 6'h21;
  parameter logic [5:0] FN_SUBU = 6'h23;
  parameter logic [5:0] FN_AND  = 6'h24;
  parameter logic [5:0] FN_OR   = 6'h25;
  parameter logic [5:0] FN_SLT  = 6'h2a;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm16;
  } i_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target26;
  } j_fmt_t;

  // one instruction word, three ways to look at it
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    j_fmt_t j;
  } instr_t;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_e;
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;   // link = pc+4
  typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} dst_sel_e;   // ra = r31

  typedef struct packed {
    alu_op_e  alu_op;
    logic     alu_src_imm;
    logic     reg_write;
    dst_sel_e dst_sel;
    wb_sel_e  wb_sel;
    logic     mem_read;
    logic     mem_write;
    logic     branch;
    logic     jump;
    logic     illegal;
  } ctrl_t;

  // wishbone classic, master to slave and back
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_m2s_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_s2m_t;

endpackage

// ==== hw/reg_file.sv ====
// register file
module reg_file (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  read_addr_s,
  input  logic [4:0]  read_addr_t,
  input  logic [4:0]  write_addr,
  input  logic [31:0] write_data,
  input  logic        write_en,
  output logic [31:0] data_s,
  output logic [31:0] data_t
);

  logic [31:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && write_addr != 5'd0) begin  // r0 stays zero
      regs[write_addr] <= write_data;
    end
  end

  // both reads are asynchronous
  assign data_s = regs[read_addr_s];
  assign data_t = regs[read_addr_t];

endmodule

// ==== tb.f ====
+incdir+include
hw/mips_pkg.sv
hw/instr_mem.sv
hw/decode_control.sv
hw/reg_file.sv
hw/alu.sv
hw/data_bus_master.sv
hw/cpu_top.sv
tests/cpu_tb.sv

// ==== include/tb_model.svh ====
// isa reference model
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef struct packed {
  logic        we;
  logic [31:0] adr;
  logic [31:0] dat;
} bus_txn_t;

logic [31:0] seed = 32'he78d;  // lfsr state
logic [31:0] prog [$];
logic [31:0] model_regs [32];
logic [31:0] model_mem [64];   // data window, bytes 0..255
logic [31:0] mem_init [64];
bus_txn_t    txns [$];         // expected bus cycles in order
logic [5:0]  fn_list [5] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT};

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] lfsr_bits(input int n);  // one lfsr step per bit
  logic [31:0] v;
  v = '0;
  for (int k = 0; k < n; k++) begin
    seed = lfsr_next(seed);
    v = {v[30:0], seed[0]};
  end
  return v;
endfunction

function automatic logic [31:0] enc_r(logic [5:0] fn, logic [4:0] rd, rs, rt);
  return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rt, rs, logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] enc_j(logic [5:0] op, logic [25:0] target);
  return {op, target};
endfunction

function automatic void build_random_program(input int n);
  logic [4:0] rd, rs, rt;
  prog.delete();
  for (int k = 0; k < 64; k++) begin
    mem_init[k] = lfsr_bits(32);
  end
  prog.push_back(enc_i(OP_ADDIU, 5'd1, 5'd0, 16'd0));  // r1 is the data base
  while (prog.size() < n) begin
    rd = 5'd2 + 5'(lfsr_bits(4));
    rs = 5'(lfsr_bits(4));
    rt = 5'(lfsr_bits(4));
    if (prog.size() == n / 2) begin  // jal over one word, then store the link
      prog.push_back(enc_j(OP_JAL, 26'(prog.size() + 2)));
      prog.push_back(enc_r(FN_ADDU, 5'd0, 5'd0, 5'd0));
      prog.push_back(enc_i(OP_SW, 5'd31, 5'd1, 16'd0));
    end else begin
      case (lfsr_bits(3))
        0, 1: prog.push_back(enc_r(fn_list[lfsr_bits(3) % 5], rd, rs, rt));
        2: prog.push_back(enc_i(OP_ADDIU, rd, rs, 16'(lfsr_bits(16))));
        3: prog.push_back(enc_i(OP_LW, rd, 5'd1, {8'd0, 6'(lfsr_bits(6)), 2'b00}));
        4: prog.push_back(enc_i(OP_SW, rt, 5'd1, {8'd0, 6'(lfsr_bits(6)), 2'b00}));
        5: prog.push_back(enc_i(OP_BEQ, rt, rs, 16'(1 + lfsr_bits(2) % 3)));
        default: prog.push_back(enc_j(OP_J, 26'(prog.size() + 2 + lfsr_bits(2) % 3)));
      endcase
    end
  end
  repeat (3) prog.push_back(enc_r(FN_ADDU, 5'd0, 5'd0, 5'd0));  // landing pad
  prog.push_back(enc_j(OP_J, 26'(prog.size())));                 // spin here
endfunction

function automatic void run_model(input int max_steps);
  logic [31:0] pc, ins, a, b, imm, ea;
  bus_txn_t    t;
  pc = '0;
  model_regs = '{default: '0};
  model_mem = mem_init;
  txns.delete();
  for (int s = 0; s < max_steps; s++) begin
    ins = prog[pc[31:2]];
    if (ins == enc_j(OP_J, pc[27:2])) break;
    a = model_regs[ins[25:21]];
    b = model_regs[ins[20:16]];
    imm = {{16{ins[15]}}, ins[15:0]};
    ea = a + imm;
    pc = pc + 32'd4;
    case (ins[31:26])
      OP_RTYPE: case (ins[5:0])
        FN_ADDU: model_regs[ins[15:11]] = a + b;
        FN_SUBU: model_regs[ins[15:11]] = a - b;
        FN_AND:  model_regs[ins[15:11]] = a & b;
        FN_OR:   model_regs[ins[15:11]] = a | b;
        FN_SLT:  model_regs[ins[15:11]] = {31'd0, $signed(a) < $signed(b)};
        default: ;
      endcase
      OP_ADDIU: model_regs[ins[20:16]] = ea;
      OP_LW: begin
        model_regs[ins[20:16]] = model_mem[ea[7:2]];
        t = '{we: 1'b0, adr: ea, dat: model_mem[ea[7:2]]};
        txns.push_back(t);
      end
      OP_SW: begin
        model_mem[ea[7:2]] = b;
        t = '{we: 1'b1, adr: ea, dat: b};
        txns.push_back(t);
      end
      OP_BEQ: if (a == b) pc = pc + {imm[29:0], 2'b00};
      OP_J:   pc = {pc[31:28], ins[25:0], 2'b00};
      OP_JAL: begin
        model_regs[31] = pc;
        pc = {pc[31:28], ins[25:0], 2'b00};
      end
      default: ;
    endcase
    model_regs[0] = '0;
  end
endfunction

`endif

// ==== tests/cpu_tb.sv ====
// cpu core testbench
module cpu_tb;
  import mips_pkg::*;

  `include "tb_model.svh"

  localparam int NUM_TESTS = 23;   // three directed, twenty random
  localparam int MAX_INSTR = 64;   // upper bound on words per program
  // each word runs at most once, a bus access costs up to 4 wait cycles plus 2
  localparam int WATCHDOG_TIME = NUM_TESTS * (MAX_INSTR * (4 + 2) + MAX_INSTR + 60) * 10;

  logic        clock;
  logic        reset;
  logic        load_en;
  logic [31:0] load_addr;
  logic [31:0] load_data;
  wb_s2m_t     wb_in = '0;
  wb_m2s_t     wb_out;

  logic [31:0] slave_mem [64];
  logic [1:0]  wait_q [$];         // wait count per expected bus cycle
  logic        seen = 1'b0;        // slave has taken its wait count
  logic [1:0]  wait_cnt = 2'd0;
  logic        in_reset_q = 1'b0;
  logic        hold_valid = 1'b0;
  wb_m2s_t     hold_req = '0;
  int          exp_idx = 0;
  int          error_count = 0;

  cpu_top #(.IMEM_WORDS(256), .RESET_PC(32'h0)) uut (
    .clock(clock), .reset(reset), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .wb_in(wb_in), .wb_out(wb_out)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("MISMATCH t=%0t %s expected %h actual %h", $time, sig, expected, actual);
    error_count++;
  endtask

  // wishbone slave backed by the data window, 0 to 3 extra wait cycles
  always @(posedge clock) begin
    logic [1:0] w;
    if (reset) begin
      wb_in <= '0;
      seen  <= 1'b0;
      for (int k = 0; k < 64; k++) begin
        slave_mem[k] <= mem_init[k];
      end
    end else if (wb_in.ack) begin
      wb_in.ack <= 1'b0;  // single-cycle ack
      seen      <= 1'b0;
    end else if (wb_out.cyc && wb_out.stb) begin
      if (seen) begin
        w = wait_cnt;
      end else if (exp_idx < wait_q.size()) begin
        w = wait_q[exp_idx];
      end else begin
        w = 2'd0;
      end
      seen <= 1'b1;
      if (w == 2'd0) begin
        wb_in.ack <= 1'b1;
        wb_in.dat <= wb_out.we ? 32'h0 : slave_mem[wb_out.adr[7:2]];
        if (wb_out.we) slave_mem[wb_out.adr[7:2]] <= wb_out.dat;
      end else begin
        wait_cnt <= w - 2'd1;
      end
    end
  end

  // bus monitor: reset idle, request hold, ordered transaction compare
  always @(posedge clock) begin
    bus_txn_t    want;
    logic [31:0] got_dat;
    in_reset_q <= reset;
    if (in_reset_q && (wb_out.cyc || wb_out.stb || wb_out.we)) begin
      $display("t=%0t bus control lines not idle around reset", $time);
      error_count++;
    end
    if (hold_valid && !reset) begin
      if (!wb_out.stb) begin
        $display("t=%0t stb dropped before the slave acknowledged", $time);
        error_count++;
      end else begin
        if (wb_out.adr !== hold_req.adr) begin
          report_mismatch("wb_out.adr", hold_req.adr, wb_out.adr);
        end
        if (wb_out.we !== hold_req.we) begin
          report_mismatch("wb_out.we", {31'd0, hold_req.we}, {31'd0, wb_out.we});
        end
        if (wb_out.dat !== hold_req.dat) begin
          report_mismatch("wb_out.dat", hold_req.dat, wb_out.dat);
        end
      end
    end
    hold_valid <= wb_out.cyc && wb_out.stb && !wb_in.ack && !reset;
    hold_req   <= wb_out;
    if (reset) begin
      exp_idx <= 0;
    end else if (wb_out.cyc && wb_out.stb && wb_in.ack) begin
      if (exp_idx >= txns.size()) begin
        $display("t=%0t unexpected bus cycle to address %h after the last one", $time,
                 wb_out.adr);
        error_count++;
      end else begin
        want    = txns[exp_idx];
        got_dat = wb_out.we ? wb_out.dat : wb_in.dat;
        if (wb_out.we !== want.we) begin
          report_mismatch("wb_out.we", {31'd0, want.we}, {31'd0, wb_out.we});
        end
        if (wb_out.adr !== want.adr) report_mismatch("wb_out.adr", want.adr, wb_out.adr);
        if (wb_out.sel !== 4'hf) begin  // word access, all byte lanes
          report_mismatch("wb_out.sel", 32'hf, {28'd0, wb_out.sel});
        end
        if (got_dat !== want.dat) report_mismatch("bus data", want.dat, got_dat);
      end
      exp_idx <= exp_idx + 1;
    end
  end

  function automatic void fill_data_memory();
    for (int k = 0; k < 64; k++) begin
      mem_init[k] = lfsr_bits(32);
    end
  endfunction

  // one random wait count per expected bus cycle
  function automatic void draw_wait_states();
    wait_q.delete();
    for (int k = 0; k < txns.size(); k++) begin
      wait_q.push_back(2'(lfsr_bits(2)));
    end
  endfunction

  function automatic void end_program();
    prog.push_back(enc_j(OP_J, 26'(prog.size())));  // spin on itself
  endfunction

  function automatic void build_alu_program();
    prog.delete();
    fill_data_memory();
    prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd0, 16'h1234));
    prog.push_back(enc_i(OP_ADDIU, 5'd3, 5'd0, 16'hfffb));  // -5
    prog.push_back(enc_r(FN_ADDU, 5'd4, 5'd2, 5'd3));
    prog.push_back(enc_r(FN_SUBU, 5'd5, 5'd3, 5'd2));
    prog.push_back(enc_r(FN_AND, 5'd6, 5'd2, 5'd3));
    prog.push_back(enc_r(FN_OR, 5'd7, 5'd2, 5'd3));
    prog.push_back(enc_r(FN_SLT, 5'd8, 5'd3, 5'd2));
    prog.push_back(enc_r(FN_SLT, 5'd9, 5'd2, 5'd3));
    prog.push_back(enc_r(FN_ADDU, 5'd0, 5'd2, 5'd3));  // r0 ignores this
    for (int r = 0; r <= 9; r++) begin
      prog.push_back(enc_i(OP_SW, 5'(r), 5'd0, 16'(4 * r)));
    end
    end_program();
  endfunction

  function automatic void build_load_program();
    prog.delete();
    fill_data_memory();
    prog.push_back(enc_i(OP_ADDIU, 5'd1, 5'd0, 16'd64));  // base
    prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd0, 16'h8765));
    prog.push_back(enc_i(OP_SW, 5'd2, 5'd1, 16'd0));
    prog.push_back(enc_i(OP_LW, 5'd3, 5'd1, 16'd0));     // reads back the store
    prog.push_back(enc_i(OP_SW, 5'd3, 5'd1, 16'd4));
    prog.push_back(enc_i(OP_LW, 5'd4, 5'd1, 16'd8));     // preloaded word
    prog.push_back(enc_i(OP_SW, 5'd4, 5'd1, 16'd12));
    prog.push_back(enc_r(FN_ADDU, 5'd5, 5'd3, 5'd4));
    prog.push_back(enc_i(OP_SW, 5'd5, 5'd1, 16'hfff0));  // negative offset
    end_program();
  endfunction

  function automatic void build_flow_program();
    prog.delete();
    fill_data_memory();
    prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd0, 16'd7));
    prog.push_back(enc_i(OP_ADDIU, 5'd3, 5'd0, 16'd7));
    prog.push_back(enc_i(OP_BEQ, 5'd3, 5'd2, 16'd1));    // taken
    prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd0, 16'd99));
    prog.push_back(enc_i(OP_SW, 5'd2, 5'd0, 16'd0));
    prog.push_back(enc_i(OP_BEQ, 5'd0, 5'd2, 16'd1));    // not taken
    prog.push_back(enc_i(OP_SW, 5'd3, 5'd0, 16'd4));
    prog.push_back(enc_j(OP_J, 26'(prog.size() + 2)));
    prog.push_back(enc_i(OP_SW, 5'd0, 5'd0, 16'd8));     // skipped by j
    prog.push_back(enc_j(OP_JAL, 26'(prog.size() + 2)));
    prog.push_back(enc_i(OP_SW, 5'd2, 5'd0, 16'd8));     // skipped by jal
    prog.push_back(enc_i(OP_SW, 5'd31, 5'd0, 16'd12));   // link value
    prog.push_back(enc_i(OP_SW, 5'd2, 5'd0, 16'd16));
    end_program();
  endfunction

  // hold reset while the program goes in through the loader port
  task automatic load_program();
    @(posedge clock);
    reset <= 1'b1;
    for (int k = 0; k < prog.size(); k++) begin
      @(posedge clock);
      load_en   <= 1'b1;
      load_addr <= 32'(k);
      load_data <= prog[k];
    end
    @(posedge clock);
    load_en <= 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
  endtask

  task automatic run_test(input string name, inout int passed);
    int errs_before;
    errs_before = error_count;
    run_model(1000);
    draw_wait_states();
    load_program();
    @(posedge clock);
    while (exp_idx < txns.size()) @(posedge clock);
    repeat (50) @(posedge clock);  // program spins, bus must stay quiet
    if (error_count == errs_before) begin
      $display("test %s: pass, %0d bus transactions", name, txns.size());
      passed++;
    end else begin
      $display("test %s: fail, %0d errors", name, error_count - errs_before);
    end
  endtask

  initial begin
    int passed;
    passed    = 0;
    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = 32'h0;
    load_data = 32'h0;
    build_alu_program();
    run_test("alu and immediate", passed);
    build_load_program();
    run_test("load and write-back", passed);
    build_flow_program();
    run_test("branch, jump and link", passed);
    for (int p = 0; p < 20; p++) begin
      build_random_program(40);
      run_test($sformatf("random program %0d", p), passed);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS, passed,
             NUM_TESTS - passed, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired at t=%0t, the core stopped making bus progress", $time);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
